/* sim.f */
+incdir+src
src/memReqPkg.sv
src/memRespPkg.sv
src/subArray.sv
src/memBank.sv
src/accessDecode.sv
src/bankArray.sv
src/readReturn.sv
src/scratchMem.sv
bench/scratchMemTb.sv

/* runSim.sh */
#!/bin/sh
# Builds the scratchpad testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f sim.f --top-module scratchMemTb -o scratchMemSim \
    > build.log 2>&1 \
    && ./obj_dir/scratchMemSim > sim.log 2>&1 \
    || echo "Build or simulation run did not complete, see build.log and sim.log"
touch sim.log
grep -q "Simulation finished: PASS" sim.log \
    && echo "Test passed" \
    || { echo "Test failed"; exit 1; }

/* bench/scratchMemTb.sv */
`timescale 1ns/100ps

`include "scratchMem_params.svh"

module scratchMemTb;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 60;
    localparam int RAND_CYCLES     = 400;
    localparam int MEM_BYTES       = `SCRATCH_BANKS * `SCRATCH_SUBS * `SCRATCH_ROWS;

    logic                 clk;
    logic                 rstN;
    memReqPkg::readReqT   rdReq;
    memReqPkg::writeReqT  wrReq;
    memRespPkg::readRespT rdResp;
    logic [7:0]           dropCount;

    // Reference memory and the addresses that hold known bytes.
    logic [`SCRATCH_DATA_W-1:0] modelMem [MEM_BYTES];
    logic                       written [MEM_BYTES];
    logic [`SCRATCH_ADDR_W-1:0] writtenList [$];
    logic [`SCRATCH_ADDR_W-1:0] dirAddr [16];
    memRespPkg::readRespT       expQ [$];
    logic [7:0]                 expDrops;
    logic [31:0]                seed;
    int                         checks;
    int                         valueErrs;
    int                         otherErrs;

    scratchMem dut0 (
        .clk       (clk),
        .rstN      (rstN),
        .rdReq     (rdReq),
        .wrReq     (wrReq),
        .rdResp    (rdResp),
        .dropCount (dropCount)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic memReqPkg::readReqT makeRead(input logic [`SCRATCH_ADDR_W-1:0] addr);
        memReqPkg::readReqT rd;
        rd.valid     = 1'b1;
        rd.addr.flat = addr;
        return rd;
    endfunction

    function automatic memReqPkg::writeReqT makeWrite(input logic [`SCRATCH_ADDR_W-1:0] addr,
                                                      input logic [`SCRATCH_DATA_W-1:0] data);
        memReqPkg::writeReqT wr;
        wr.valid     = 1'b1;
        wr.addr.flat = addr;
        wr.data      = data;
        return wr;
    endfunction

    // Same bank and sub-array in one cycle means the read keeps the old byte.
    function automatic memRespPkg::readRespT expectResp(input memReqPkg::readReqT rd,
                                                        input memReqPkg::writeReqT wr);
        memRespPkg::readRespT resp;
        logic                 clash;
        resp  = '0;
        clash = rd.valid && wr.valid
            && (rd.addr.flat[10:9] == wr.addr.flat[10:9])
            && (rd.addr.flat[8:7] == wr.addr.flat[8:7]);
        if (rd.valid) begin
            resp.valid        = 1'b1;
            resp.addr         = rd.addr.flat;
            resp.data         = modelMem[rd.addr.flat];
            resp.writeDropped = clash;
        end
        return resp;
    endfunction

    task automatic checkResp(input memRespPkg::readRespT got, input memRespPkg::readRespT want);
        checks++;
        if (got.valid !== want.valid) begin
            otherErrs++;
            if (want.valid) begin
                $display("Read response missing at %0t", $time);
            end else begin
                $display("Read response arrived at %0t when none was expected", $time);
            end
        end else if (want.valid) begin
            if (got.addr !== want.addr) begin
                valueErrs++;
                $display("Fail rdResp.addr got %h expected %h", got.addr, want.addr);
            end
            if (got.data !== want.data) begin
                valueErrs++;
                $display("Fail rdResp.data got %h expected %h (addr %h)",
                         got.data, want.data, want.addr);
            end
            if (got.writeDropped !== want.writeDropped) begin
                valueErrs++;
                $display("Fail rdResp.writeDropped got %h expected %h",
                         got.writeDropped, want.writeDropped);
            end
        end
    endtask

    task automatic checkCount(input logic [7:0] got, input logic [7:0] want);
        checks++;
        if (got !== want) begin
            valueErrs++;
            $display("Fail dropCount got %h expected %h", got, want);
        end
    endtask

    // Drives one cycle of requests and records what should come back.
    task automatic issue(input memReqPkg::readReqT rd, input memReqPkg::writeReqT wr);
        memRespPkg::readRespT want;
        @(negedge clk);
        want = expectResp(rd, wr);
        expQ.push_back(want);
        if (want.writeDropped) begin
            expDrops = (expDrops == 8'hff) ? expDrops : expDrops + 8'd1;
        end else if (wr.valid) begin
            modelMem[wr.addr.flat] = wr.data;
            if (!written[wr.addr.flat]) begin
                written[wr.addr.flat] = 1'b1;
                writtenList.push_back(wr.addr.flat);
            end
        end
        rdReq = rd;
        wrReq = wr;
    endtask

    task automatic idleFor(input int n);
        for (int i = 0; i < n; i++) begin
            issue('0, '0);
        end
    endtask

    task automatic writeOnly(input logic [`SCRATCH_ADDR_W-1:0] addr,
                             input logic [`SCRATCH_DATA_W-1:0] data);
        issue('0, makeWrite(addr, data));
    endtask

    task automatic readOnly(input logic [`SCRATCH_ADDR_W-1:0] addr);
        issue(makeRead(addr), '0);
    endtask

    // Compares between edges, after the response register has settled.
    initial begin
        memRespPkg::readRespT want;
        wait (rstN === 1'b1);
        forever begin
            @(posedge clk);
            #2;
            want = '0;
            if (expQ.size() > 0) begin
                want = expQ.pop_front();
            end
            checkResp(rdResp, want);
            checkCount(dropCount, expDrops);
        end
    end

    initial begin
        #((DIRECTED_CYCLES + RAND_CYCLES + RESET_CYCLES + 100) * CLK_PERIOD);
        $display("Watchdog expired at %0t, the test did not finish in time", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [31:0]                r;
        logic [31:0]                d;
        logic [`SCRATCH_ADDR_W-1:0] a;
        logic [`SCRATCH_ADDR_W-1:0] w1;
        logic [`SCRATCH_ADDR_W-1:0] w2;
        memReqPkg::readReqT         rd;
        memReqPkg::writeReqT        wr;
        int                         idx;
        clk       = 1'b0;
        rstN      = 1'b0;
        rdReq     = '0;
        wrReq     = '0;
        seed      = 32'hab91;
        expDrops  = '0;
        checks    = 0;
        valueErrs = 0;
        otherErrs = 0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            written[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rstN = 1'b1;
        idleFor(4);

        // One byte per bank and sub-array, rows 0 and 127 included.
        for (int i = 0; i < 16; i++) begin
            r = nextRand();
            d = nextRand();
            a[10:9] = 2'(i / 4);
            a[8:7]  = 2'(i % 4);
            a[6:0]  = (i == 0) ? 7'd0 : ((i == 15) ? 7'd127 : r[6:0]);
            dirAddr[i] = a;
            writeOnly(a, d[7:0]);
        end
        // Sub-array outer loop, so consecutive reads hit different banks.
        for (int s = 0; s < 4; s++) begin
            for (int b = 0; b < 4; b++) begin
                readOnly(dirAddr[b * 4 + s]);
            end
        end

        // Read and write in one cycle, different sub-arrays.
        r  = nextRand();
        d  = nextRand();
        w1 = {dirAddr[5][10:9], dirAddr[5][8:7] ^ 2'b01, r[6:0]};
        issue(makeRead(dirAddr[5]), makeWrite(w1, d[7:0]));
        r  = nextRand();
        d  = nextRand();
        w2 = {dirAddr[10][10:9] + 2'b01, dirAddr[10][8:7], r[6:0]};
        issue(makeRead(dirAddr[10]), makeWrite(w2, d[7:0]));
        readOnly(w1);
        readOnly(w2);

        // Collision on bank 0, sub-array 3.
        a = dirAddr[3] ^ 11'h040;
        d = nextRand();
        writeOnly(a, d[7:0]);
        d = nextRand();
        issue(makeRead(dirAddr[3]), makeWrite(a, d[7:0]));
        readOnly(a);
        readOnly(dirAddr[3]);

        for (int c = 0; c < RAND_CYCLES; c++) begin
            r   = nextRand();
            d   = nextRand();
            rd  = '0;
            wr  = '0;
            idx = nextRand() % writtenList.size();
            if (r[8]) begin
                rd = makeRead(writtenList[idx]);
            end
            if (r[9]) begin
                a  = r[11] ? r[30:20] : writtenList[(idx + 1) % writtenList.size()];
                wr = makeWrite(a, d[7:0]);
            end
            if (r[14:12] == 3'd0) begin
                rd = makeRead(writtenList[idx]);
                wr = makeWrite({writtenList[idx][10:7], d[22:16]}, d[7:0]);
            end
            issue(rd, wr);
        end

        idleFor(3);
        @(negedge clk);
        checkCount(dropCount, expDrops);
        $display("Checks %0d, value errors %0d, other errors %0d, writes dropped %0d",
                 checks, valueErrs, otherErrs, expDrops);
        if (valueErrs == 0 && otherErrs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* src/scratchMem.sv */
`timescale 1ns/100ps

`include "scratchMem_params.svh"

module scratchMem (
    input  logic                 clk,
    input  logic                 rstN,
    input  memReqPkg::readReqT   rdReq,
    input  memReqPkg::writeReqT  wrReq,
    output memRespPkg::readRespT rdResp,
    output logic [7:0]           dropCount
);

    memReqPkg::bankCmdT         bankCmd [`SCRATCH_BANKS];
    logic                       rdFire;
    logic [`SCRATCH_ADDR_W-1:0] rdAddr;
    logic                       collision;
    logic [`SCRATCH_DATA_W-1:0] rdData;

    // Decode.
    accessDecode decode0 (
        .rdReq     (rdReq),
        .wrReq     (wrReq),
        .bankCmd   (bankCmd),
        .rdFire    (rdFire),
        .rdAddr    (rdAddr),
        .collision (collision)
    );

    // Execute.
    bankArray banks0 (
        .clk     (clk),
        .rstN    (rstN),
        .bankCmd (bankCmd),
        .rdData  (rdData)
    );

    // Result.
    readReturn return0 (
        .clk       (clk),
        .rstN      (rstN),
        .rdFire    (rdFire),
        .rdAddr    (rdAddr),
        .collision (collision),
        .rdData    (rdData),
        .rdResp    (rdResp),
        .dropCount (dropCount)
    );

endmodule

/* src/readReturn.sv */
`timescale 1ns/100ps

`include "scratchMem_params.svh"

module readReturn (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       rdFire,
    input  logic [`SCRATCH_ADDR_W-1:0] rdAddr,
    input  logic                       collision,
    input  logic [`SCRATCH_DATA_W-1:0] rdData,
    output memRespPkg::readRespT       rdResp,
    output logic [7:0]                 dropCount
);

    logic                       validQ;
    logic                       droppedQ;
    logic [`SCRATCH_ADDR_W-1:0] addrQ;

    // Lines up with the sub-array output register.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ   <= 1'b0;
            droppedQ <= 1'b0;
        end else begin
            validQ   <= rdFire;
            droppedQ <= collision;
        end
    end

    always_ff @(posedge clk) begin
        if (rdFire) begin
            addrQ <= rdAddr;
        end
    end

    // Saturates at 255.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dropCount <= '0;
        end else if (collision && (dropCount != 8'hff)) begin
            dropCount <= dropCount + 8'd1;
        end
    end

    always_comb begin
        rdResp.valid        = validQ;
        rdResp.addr         = addrQ;
        rdResp.data         = rdData;
        rdResp.writeDropped = droppedQ;
    end

endmodule

/* src/bankArray.sv */
`timescale 1ns/100ps

`include "scratchMem_params.svh"

module bankArray (
    input  logic                       clk,
    input  logic                       rstN,
    input  memReqPkg::bankCmdT         bankCmd [`SCRATCH_BANKS],
    output logic [`SCRATCH_DATA_W-1:0] rdData
);

    logic [`SCRATCH_DATA_W-1:0] bankData [`SCRATCH_BANKS];

    for (genvar g = 0; g < `SCRATCH_BANKS; g++) begin : genBank
        memBank bank0 (
            .clk    (clk),
            .rstN   (rstN),
            .cmd    (bankCmd[g]),
            .rdData (bankData[g])
        );
    end

    // Idle banks return zero.
    always_comb begin
        rdData = '0;
        for (int i = 0; i < `SCRATCH_BANKS; i++) begin
            rdData = rdData | bankData[i];
        end
    end

endmodule

/* src/accessDecode.sv */
`timescale 1ns/100ps

`include "scratchMem_params.svh"

module accessDecode (
    input  memReqPkg::readReqT         rdReq,
    input  memReqPkg::writeReqT        wrReq,
    output memReqPkg::bankCmdT         bankCmd [`SCRATCH_BANKS],
    output logic                       rdFire,
    output logic [`SCRATCH_ADDR_W-1:0] rdAddr,
    output logic                       collision
);

    logic                      sameBank;
    logic                      sameSub;
    logic [`SCRATCH_BANKS-1:0] rdBankSel;
    logic [`SCRATCH_BANKS-1:0] wrBankSel;

    assign sameBank = rdReq.addr.fields.bank == wrReq.addr.fields.bank;
    assign sameSub  = rdReq.addr.fields.sub == wrReq.addr.fields.sub;

    // A sub-array has one row address, so the read keeps it and the write is lost.
    assign collision = rdReq.valid && wrReq.valid && sameBank && sameSub;

    always_comb begin
        rdBankSel = '0;
        wrBankSel = '0;
        rdBankSel[rdReq.addr.fields.bank] = rdReq.valid;
        wrBankSel[wrReq.addr.fields.bank] = wrReq.valid && !collision;
    end

    // Every bank sees the same rows and data; only the enables differ.
    always_comb begin
        for (int b = 0; b < `SCRATCH_BANKS; b++) begin
            bankCmd[b].rdEn  = rdBankSel[b];
            bankCmd[b].wrEn  = wrBankSel[b];
            bankCmd[b].rdSub = rdReq.addr.fields.sub;
            bankCmd[b].wrSub = wrReq.addr.fields.sub;
            bankCmd[b].rdRow = rdReq.addr.fields.row;
            bankCmd[b].wrRow = wrReq.addr.fields.row;
            bankCmd[b].data  = wrReq.data;
        end
    end

    assign rdFire = rdReq.valid;
    assign rdAddr = rdReq.addr.flat;

endmodule

/* src/memBank.sv */
`timescale 1ns/100ps

`include "scratchMem_params.svh"

module memBank (
    input  logic                       clk,
    input  logic                       rstN,
    input  memReqPkg::bankCmdT         cmd,
    output logic [`SCRATCH_DATA_W-1:0] rdData
);

    logic [`SCRATCH_SUBS-1:0]   rdSel;
    logic [`SCRATCH_SUBS-1:0]   wrSel;
    logic [`SCRATCH_ROW_W-1:0]  subRow [`SCRATCH_SUBS];
    logic [`SCRATCH_DATA_W-1:0] subData [`SCRATCH_SUBS];

    // One-hot sub-array enables.
    always_comb begin
        rdSel = '0;
        wrSel = '0;
        if (cmd.rdEn) begin
            rdSel[cmd.rdSub] = 1'b1;
        end
        if (cmd.wrEn) begin
            wrSel[cmd.wrSub] = 1'b1;
        end
    end

    for (genvar g = 0; g < `SCRATCH_SUBS; g++) begin : genSub
        // The read row goes to the sub-array being read, the write row to the rest.
        assign subRow[g] = rdSel[g] ? cmd.rdRow : cmd.wrRow;

        subArray sub0 (
            .clk    (clk),
            .rstN   (rstN),
            .rdEn   (rdSel[g]),
            .wrEn   (wrSel[g]),
            .row    (subRow[g]),
            .wrData (cmd.data),
            .rdData (subData[g])
        );
    end

    // Only the sub-array that was read holds a non-zero byte.
    always_comb begin
        rdData = '0;
        for (int i = 0; i < `SCRATCH_SUBS; i++) begin
            rdData = rdData | subData[i];
        end
    end

endmodule

/* src/subArray.sv */
`timescale 1ns/100ps

`include "scratchMem_params.svh"

module subArray (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       rdEn,
    input  logic                       wrEn,
    input  logic [`SCRATCH_ROW_W-1:0]  row,
    input  logic [`SCRATCH_DATA_W-1:0] wrData,
    output logic [`SCRATCH_DATA_W-1:0] rdData
);

    logic [`SCRATCH_DATA_W-1:0] mem [`SCRATCH_ROWS];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[row] <= wrData;
        end
    end

    // Idle cycles load zero so the bank can OR its sub-arrays together.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdData <= '0;
        end else if (rdEn) begin
            rdData <= mem[row];
        end else begin
            rdData <= '0;
        end
    end

endmodule

/* src/memRespPkg.sv */
`include "scratchMem_params.svh"

package memRespPkg;

    // Read response, one cycle after the read strobe.
    typedef struct packed {
        logic                       valid;
        logic [`SCRATCH_ADDR_W-1:0] addr;
        logic [`SCRATCH_DATA_W-1:0] data;
        logic                       writeDropped;
    } readRespT;

endpackage

/* src/memReqPkg.sv */
`include "scratchMem_params.svh"

package memReqPkg;

    // Bank on top, row at the bottom.
    typedef struct packed {
        logic [`SCRATCH_BANK_W-1:0] bank;
        logic [`SCRATCH_SUB_W-1:0]  sub;
        logic [`SCRATCH_ROW_W-1:0]  row;
    } memAddrFieldsT;

    // One address word, seen flat or split into its fields.
    typedef union packed {
        logic [`SCRATCH_ADDR_W-1:0] flat;
        memAddrFieldsT              fields;
    } memAddrU;

    typedef struct packed {
        logic    valid;
        memAddrU addr;
    } readReqT;

    typedef struct packed {
        logic                       valid;
        memAddrU                    addr;
        logic [`SCRATCH_DATA_W-1:0] data;
    } writeReqT;

    // Command handed to one bank for the current cycle.
    typedef struct packed {
        logic                       rdEn;
        logic                       wrEn;
        logic [`SCRATCH_SUB_W-1:0]  rdSub;
        logic [`SCRATCH_SUB_W-1:0]  wrSub;
        logic [`SCRATCH_ROW_W-1:0]  rdRow;
        logic [`SCRATCH_ROW_W-1:0]  wrRow;
        logic [`SCRATCH_DATA_W-1:0] data;
    } bankCmdT;

endpackage

/* src/scratchMem_params.svh */
`ifndef SCRATCH_MEM_PARAMS_SVH
`define SCRATCH_MEM_PARAMS_SVH

// Geometry of the scratchpad.
`define SCRATCH_BANKS   4
`define SCRATCH_SUBS    4
`define SCRATCH_ROWS    128
`define SCRATCH_DATA_W  8

// Field widths of the byte address.
`define SCRATCH_BANK_W  $clog2(`SCRATCH_BANKS)
`define SCRATCH_SUB_W   $clog2(`SCRATCH_SUBS)
`define SCRATCH_ROW_W   $clog2(`SCRATCH_ROWS)
`define SCRATCH_ADDR_W  (`SCRATCH_BANK_W + `SCRATCH_SUB_W + `SCRATCH_ROW_W)

`endif
